/* list.f */
+incdir+include
logic/elink_pkg.sv
logic/tx_capture.sv
logic/tx_sequencer.sv
logic/tx_serializer.sv
logic/elink_tx.sv
tb/elink_tx_tb.sv

/* Makefile */
TOOL    = verilator
TOP     = elink_tx_tb
FLIST   = list.f
FLAGS   = --binary --timing --assert -j 0
OBJDIR  = obj_dir
LOG     = sim.log
PASS    = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# The log decides, not the simulator exit code
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/elink_tx_tb.sv */
`include "elink_defs_defs.svh"

module elink_tx_tb;

   localparam int CLK_PERIOD      = 100;
   localparam int NUM_GROUPS      = 24;
   // Up to three continuations per group
   localparam int MAX_PACKETS     = NUM_GROUPS * 4;
   localparam int WATCHDOG_CYCLES = MAX_PACKETS * 12 + NUM_GROUPS * 4 + 60;

   logic                     tx_lclk = 1'b0;
   logic                     tx_lclk90 = 1'b0;
   logic                     reset;
   elink_pkg::emesh_packet_t tx_packet;
   logic                     tx_access;
   logic                     tx_burst;
   logic                     tx_io_wait;
   logic [7:0]               txo_data_p;
   logic [7:0]               txo_data_n;
   logic                     txo_frame_p;
   logic                     txo_frame_n;
   logic                     txo_lclk_p;
   logic                     txo_lclk_n;
   logic                     txi_wr_wait;
   logic                     txi_rd_wait;
   logic                     tx_wr_wait;
   logic                     tx_rd_wait;

   // Stimulus side
   logic [31:0]              lfsr_state = 32'hef97;
   logic [31:0]              rnd;
   int                       gap;
   int                       n_cont;
   int                       drain;
   int                       end_errors = 0;

   // Reference model, written by the monitor only
   elink_pkg::link_state_t   m_state;
   elink_pkg::link_state_t   m_prev;
   elink_pkg::link_state_t   m_next;
   logic                     accept;
   logic                     exp_frame;
   logic                     exp_wait;
   logic                     exp_clk;
   logic                     wr_cur;
   logic                     wr_prev;
   logic                     rd_cur;
   logic                     rd_prev;
   int                       rel_edges;
   logic [7:0]               exp_bytes[$];
   logic [7:0]               exp_b;
   int                       n_errors = 0;
   int                       n_packets = 0;
   int                       n_bytes = 0;

   elink_tx i_elink_tx
   (
      .tx_lclk     (tx_lclk),
      .tx_lclk90   (tx_lclk90),
      .reset       (reset),
      .tx_packet   (tx_packet),
      .tx_access   (tx_access),
      .tx_burst    (tx_burst),
      .tx_io_wait  (tx_io_wait),
      .txo_data_p  (txo_data_p),
      .txo_data_n  (txo_data_n),
      .txo_frame_p (txo_frame_p),
      .txo_frame_n (txo_frame_n),
      .txo_lclk_p  (txo_lclk_p),
      .txo_lclk_n  (txo_lclk_n),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .tx_wr_wait  (tx_wr_wait),
      .tx_rd_wait  (tx_rd_wait)
   );

   // ##############################
   // Clocks
   // ##############################

   always #(CLK_PERIOD / 2) tx_lclk = ~tx_lclk;

   // Quarter period behind tx_lclk
   always @(tx_lclk)
   begin
      #(CLK_PERIOD / 4);
      tx_lclk90 = tx_lclk;
   end

   // ##############################
   // Random source
   // ##############################

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // ##############################
   // Fabric driver
   // ##############################

   task automatic drive_pushback;
      logic [31:0] r;
      r = rand_bits(2);
      txi_wr_wait = r[1];
      txi_rd_wait = r[0];
   endtask

   task automatic idle_cycle;
      @(negedge tx_lclk);
      tx_access = 1'b0;
      tx_burst  = 1'b0;
      drive_pushback();
   endtask

   // Present one packet and hold it until accepted
   task automatic send_packet(input logic burst);
      elink_pkg::emesh_packet_t p;
      logic [31:0]              r;
      p.srcaddr  = rand_bits(32);
      p.data     = rand_bits(32);
      p.dstaddr  = rand_bits(32);
      r          = rand_bits(7);
      p.ctrlmode = r[6:3];
      p.datamode = r[2:1];
      p.write    = r[0];
      p.access   = 1'b1;
      @(negedge tx_lclk);
      tx_packet = p;
      tx_access = 1'b1;
      tx_burst  = burst;
      drive_pushback();
      @(posedge tx_lclk);
      // Wait level as it stood before this edge
      while (tx_io_wait)
      begin
         @(negedge tx_lclk);
         drive_pushback();
         @(posedge tx_lclk);
      end
   endtask

   // ##############################
   // Expected byte stream
   // ##############################

   // High byte first, then low byte
   task automatic push_slice(input logic [15:0] s);
      exp_bytes.push_back(s[15:8]);
      exp_bytes.push_back(s[7:0]);
   endtask

   task automatic expand_packet(input elink_pkg::emesh_packet_t p, input logic with_header);
      logic [47:0] hdr;
      logic [63:0] pay;
      // Read flag, 7 pad bits, then the control fields
      hdr = {~p.write, 7'd0, p.ctrlmode, p.dstaddr, p.datamode, p.write, p.access};
      pay = {p.data, p.srcaddr};
      if (with_header)
      begin
         push_slice(hdr[47:32]);
         push_slice(hdr[31:16]);
         push_slice(hdr[15:0]);
      end
      push_slice(pay[63:48]);
      push_slice(pay[47:32]);
      push_slice(pay[31:16]);
      push_slice(pay[15:0]);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      n_errors++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
   endtask

   task automatic report_problem(input string what);
      n_errors++;
      $display("Error: %s", what);
   endtask

   // One DDR half on the data pins
   task automatic sample_byte(input string name);
      if (txo_data_n !== ~txo_data_p)
         report_problem("txo_data_n is not the inverse of txo_data_p");
      if (txo_frame_p)
      begin
         if (exp_bytes.size() == 0)
            report_problem("frame is high but no byte is expected");
         else
         begin
            exp_b = exp_bytes.pop_front();
            n_bytes++;
            if (txo_data_p !== exp_b)
               report_mismatch(name, 32'(exp_b), 32'(txo_data_p));
         end
      end
      else if ((n_packets == 0) && (txo_data_p !== 8'h00))
         report_mismatch("quiet data", 32'h0, 32'(txo_data_p));
   endtask

   // ##############################
   // Monitor and model
   // ##############################

   always @(posedge tx_lclk)
   begin
      if (reset)
      begin
         m_state   = `ELINK_ST_IDLE;
         m_prev    = `ELINK_ST_IDLE;
         exp_frame = 1'b0;
         exp_wait  = 1'b0;
         rel_edges = 0;
         wr_cur    = 1'b0;
         wr_prev   = 1'b0;
         rd_cur    = 1'b0;
         rd_prev   = 1'b0;
      end
      else
      begin
         // Accepted when offered with the wait low
         accept = tx_access & ~tx_io_wait;
         if (accept)
         begin
            if ((m_state != `ELINK_ST_IDLE) && !((m_state == `ELINK_ST_CYC7) && tx_burst))
               report_problem("packet accepted outside idle and a bursting cycle 7");
            // Full frame from idle, payload only when continuing
            expand_packet(tx_packet, m_state == `ELINK_ST_IDLE);
            n_packets++;
         end
         case (m_state)
            `ELINK_ST_IDLE:
               m_next = tx_access ? `ELINK_ST_CYC1 : `ELINK_ST_IDLE;
            `ELINK_ST_CYC7:
               m_next = (tx_access && tx_burst) ? `ELINK_ST_CYC4 : `ELINK_ST_IDLE;
            default:
               m_next = m_state + 3'd1;
         endcase
         // Frame trails the state by two edges
         exp_frame = (m_prev != `ELINK_ST_IDLE);
         m_prev    = m_state;
         m_state   = m_next;
         // Wait open in idle, and in cycle 7 while bursting
         exp_wait  = !((m_state == `ELINK_ST_IDLE) ||
                       ((m_state == `ELINK_ST_CYC7) && tx_burst));
         if (rel_edges < 2)
            rel_edges++;
         // Pushback pin history
         wr_prev = wr_cur;
         wr_cur  = txi_wr_wait;
         rd_prev = rd_cur;
         rd_cur  = txi_rd_wait;
      end
      exp_clk = (rel_edges >= 2) ? 1'b1 : 1'b0;

      #(CLK_PERIOD / 4);
      // Clock high, first byte of the slice
      if (txo_frame_p !== exp_frame)
         report_mismatch("frame", 32'(exp_frame), 32'(txo_frame_p));
      if (txo_frame_n !== ~txo_frame_p)
         report_problem("txo_frame_n is not the inverse of txo_frame_p");
      if (tx_io_wait !== exp_wait)
         report_mismatch("io_wait", 32'(exp_wait), 32'(tx_io_wait));
      if (tx_wr_wait !== wr_prev)
         report_mismatch("wr_wait", 32'(wr_prev), 32'(tx_wr_wait));
      if (tx_rd_wait !== rd_prev)
         report_mismatch("rd_wait", 32'(rd_prev), 32'(tx_rd_wait));
      sample_byte("high byte");

      #(CLK_PERIOD / 8);
      // tx_lclk90 high here
      if (txo_lclk_p !== exp_clk)
         report_mismatch("lclk high phase", 32'(exp_clk), 32'(txo_lclk_p));
      if (txo_lclk_n !== ~txo_lclk_p)
         report_problem("txo_lclk_n is not the inverse of txo_lclk_p");

      #(CLK_PERIOD * 3 / 8);
      sample_byte("low byte");

      #(CLK_PERIOD / 8);
      // tx_lclk90 low here
      if (txo_lclk_p !== 1'b0)
         report_mismatch("lclk low phase", 32'h0, 32'(txo_lclk_p));
      if (txo_lclk_n !== ~txo_lclk_p)
         report_problem("txo_lclk_n is not the inverse of txo_lclk_p");
   end

   // ##############################
   // Test sequence
   // ##############################

   initial
   begin
      reset       = 1'b1;
      tx_packet   = '0;
      tx_access   = 1'b0;
      tx_burst    = 1'b0;
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      repeat (4) @(negedge tx_lclk);
      reset = 1'b0;

      for (int g = 0; g < NUM_GROUPS; g++)
      begin
         // Idle gap of 0 to 3 cycles
         rnd = rand_bits(2);
         gap = int'(rnd[1:0]);
         repeat (gap) idle_cycle();
         // First packet opens a frame, the rest continue it
         rnd    = rand_bits(2);
         n_cont = int'(rnd[1:0]);
         for (int k = 0; k <= n_cont; k++)
            send_packet(k != 0);
      end
      idle_cycle();

      // Let the last frame leave the pins
      drain = 0;
      while (((exp_bytes.size() != 0) || txo_frame_p) && (drain < 20))
      begin
         @(posedge tx_lclk);
         drain++;
      end
      repeat (2) @(negedge tx_lclk);
      if (exp_bytes.size() != 0)
      begin
         $display("Error: %0d expected bytes were never sent", exp_bytes.size());
         end_errors++;
      end
      if (n_packets == 0)
      begin
         $display("Error: no packet was accepted");
         end_errors++;
      end

      $display("Packets %0d, bytes %0d, errors %0d", n_packets, n_bytes,
               n_errors + end_errors);
      if ((n_errors + end_errors) == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Bound on the whole run
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Error: timeout, the run did not finish");
      $display("Checks failed");
      $finish;
   end

endmodule

/* logic/elink_tx.sv */
module elink_tx
(
   input  logic                     tx_lclk,
   input  logic                     tx_lclk90,
   input  logic                     reset,
   input  elink_pkg::emesh_packet_t tx_packet,
   input  logic                     tx_access,
   input  logic                     tx_burst,
   output logic                     tx_io_wait,
   output logic [7:0]               txo_data_p,
   output logic [7:0]               txo_data_n,
   output logic                     txo_frame_p,
   output logic                     txo_frame_n,
   output logic                     txo_lclk_p,
   output logic                     txo_lclk_n,
   input  logic                     txi_wr_wait,
   input  logic                     txi_rd_wait,
   output logic                     tx_wr_wait,
   output logic                     tx_rd_wait
);

   logic                   take;
   elink_pkg::link_word_u  hdr_word;
   elink_pkg::link_word_u  pay_word;
   elink_pkg::link_word_u  link_word;
   elink_pkg::link_state_t state;

   // Packet register and word packing
   tx_capture i_tx_capture
   (
      .tx_lclk   (tx_lclk),
      .reset     (reset),
      .take      (take),
      .tx_packet (tx_packet),
      .hdr_word  (hdr_word),
      .pay_word  (pay_word)
   );

   // Frame FSM and link word
   tx_sequencer i_tx_sequencer
   (
      .tx_lclk    (tx_lclk),
      .reset      (reset),
      .tx_access  (tx_access),
      .tx_burst   (tx_burst),
      .hdr_word   (hdr_word),
      .pay_word   (pay_word),
      .take       (take),
      .link_word  (link_word),
      .state      (state),
      .tx_io_wait (tx_io_wait)
   );

   // Slices onto the pins
   tx_serializer i_tx_serializer
   (
      .tx_lclk     (tx_lclk),
      .tx_lclk90   (tx_lclk90),
      .reset       (reset),
      .state       (state),
      .link_word   (link_word),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .txo_data_p  (txo_data_p),
      .txo_data_n  (txo_data_n),
      .txo_frame_p (txo_frame_p),
      .txo_frame_n (txo_frame_n),
      .txo_lclk_p  (txo_lclk_p),
      .txo_lclk_n  (txo_lclk_n),
      .tx_wr_wait  (tx_wr_wait),
      .tx_rd_wait  (tx_rd_wait)
   );

endmodule

/* logic/tx_serializer.sv */
`include "elink_defs_defs.svh"

module tx_serializer
(
   input  logic                   tx_lclk,
   input  logic                   tx_lclk90,
   input  logic                   reset,
   input  elink_pkg::link_state_t state,
   input  elink_pkg::link_word_u  link_word,
   input  logic                   txi_wr_wait,
   input  logic                   txi_rd_wait,
   output logic [7:0]             txo_data_p,
   output logic [7:0]             txo_data_n,
   output logic                   txo_frame_p,
   output logic                   txo_frame_n,
   output logic                   txo_lclk_p,
   output logic                   txo_lclk_n,
   output logic                   tx_wr_wait,
   output logic                   tx_rd_wait
);

   elink_pkg::link_state_t    state_d;
   logic [`ELINK_SLICE_W-1:0] slice_q;
   logic                      frame_q;
   logic                      io_reset_in;
   logic                      io_reset;
   logic [1:0]                wait_meta;
   logic [1:0]                wait_sync;

   // ##############################
   // Slice pipeline
   // ##############################

   // Delayed state picks the slice and the frame
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         state_d <= `ELINK_ST_IDLE;
         frame_q <= 1'b0;
         slice_q <= '0;
      end
      else
      begin
         state_d <= state;
         frame_q <= (state_d != `ELINK_ST_IDLE);
         case (state_d)
            // Header view, read flag leads
            `ELINK_ST_CYC1:
               slice_q <= {link_word.hdr.read, link_word.hdr.pad,
                           link_word.hdr.ctrlmode, link_word.hdr.dstaddr[31:28]};
            `ELINK_ST_CYC2:
               slice_q <= link_word.hdr.dstaddr[27:12];
            `ELINK_ST_CYC3:
               slice_q <= {link_word.hdr.dstaddr[11:0], link_word.hdr.datamode,
                           link_word.hdr.write, link_word.hdr.access};
            // Payload view, data before srcaddr
            `ELINK_ST_CYC4:
               slice_q <= link_word.pay.data[31:16];
            `ELINK_ST_CYC5:
               slice_q <= link_word.pay.data[15:0];
            `ELINK_ST_CYC6:
               slice_q <= link_word.pay.srcaddr[31:16];
            `ELINK_ST_CYC7:
               slice_q <= link_word.pay.srcaddr[15:0];
            default:
               slice_q <= '0;
         endcase
      end
   end

   // ##############################
   // Reset and pushback sync
   // ##############################

   // Pins stay quiet two edges past reset
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         io_reset_in <= 1'b1;
         io_reset    <= 1'b1;
      end
      else
      begin
         io_reset_in <= 1'b0;
         io_reset    <= io_reset_in;
      end
   end

   // Bit 1 write pushback, bit 0 read pushback
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         wait_meta <= '0;
         wait_sync <= '0;
      end
      else
      begin
         wait_meta <= {txi_wr_wait, txi_rd_wait};
         wait_sync <= wait_meta;
      end
   end

   assign tx_wr_wait = wait_sync[1];
   assign tx_rd_wait = wait_sync[0];

   // ##############################
   // Pin drivers
   // ##############################

   // DDR byte, high half while clock high
   assign txo_data_p  = tx_lclk ? slice_q[15:8] : slice_q[7:0];
   assign txo_data_n  = ~txo_data_p;

   assign txo_frame_p = frame_q & ~io_reset;
   assign txo_frame_n = ~txo_frame_p;

   // Forwarded clock, 90 degrees late
   assign txo_lclk_p  = tx_lclk90 & ~io_reset;
   assign txo_lclk_n  = ~txo_lclk_p;

   // Frame closes only after a last payload slice
   a_frame_state : assert property (@(posedge tx_lclk) disable iff (reset)
      $fell(frame_q) |-> ($past(state_d, 2) == `ELINK_ST_CYC7));

endmodule

/* logic/tx_sequencer.sv */
`include "elink_defs_defs.svh"

module tx_sequencer
(
   input  logic                   tx_lclk,
   input  logic                   reset,
   input  logic                   tx_access,
   input  logic                   tx_burst,
   input  elink_pkg::link_word_u  hdr_word,
   input  elink_pkg::link_word_u  pay_word,
   output logic                   take,
   output elink_pkg::link_word_u  link_word,
   output elink_pkg::link_state_t state,
   output logic                   tx_io_wait
);

   elink_pkg::link_state_t state_nxt;
   logic                   in_idle;
   logic                   in_last;
   logic                   wait_nxt;

   assign in_idle = (state == `ELINK_ST_IDLE);
   assign in_last = (state == `ELINK_ST_CYC7);

   // ##############################
   // Acceptance
   // ##############################

   // New frame from idle
   // Payload-only group at end of cycle 7 when bursting
   assign take = tx_access & (in_idle | (in_last & tx_burst));

   // ##############################
   // Frame state machine
   // ##############################

   always_comb
   begin
      case (state)
         `ELINK_ST_IDLE:
            state_nxt = tx_access ? `ELINK_ST_CYC1 : `ELINK_ST_IDLE;
         // Header slices
         `ELINK_ST_CYC1:
            state_nxt = `ELINK_ST_CYC2;
         `ELINK_ST_CYC2:
            state_nxt = `ELINK_ST_CYC3;
         `ELINK_ST_CYC3:
            state_nxt = `ELINK_ST_CYC4;
         // Payload slices
         `ELINK_ST_CYC4:
            state_nxt = `ELINK_ST_CYC5;
         `ELINK_ST_CYC5:
            state_nxt = `ELINK_ST_CYC6;
         `ELINK_ST_CYC6:
            state_nxt = `ELINK_ST_CYC7;
         // Loop back for burst, else close the frame
         `ELINK_ST_CYC7:
            state_nxt = (tx_burst & tx_access) ? `ELINK_ST_CYC4 : `ELINK_ST_IDLE;
         default:
            state_nxt = `ELINK_ST_IDLE;
      endcase
   end

   // Wait follows the state being entered
   // Open only in idle and in a bursting cycle 7
   assign wait_nxt = (state_nxt != `ELINK_ST_IDLE) &
                     ~((state_nxt == `ELINK_ST_CYC7) & tx_burst);

   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         state      <= `ELINK_ST_IDLE;
         tx_io_wait <= 1'b0;
      end
      else
      begin
         state      <= state_nxt;
         tx_io_wait <= wait_nxt;
      end
   end

   // ##############################
   // Link word load
   // ##############################

   // Header one edge after accept, payload for every group
   always_ff @(posedge tx_lclk)
   begin
      if (state == `ELINK_ST_CYC1)
         link_word <= hdr_word;
      else if (state == `ELINK_ST_CYC4)
         link_word <= pay_word;
   end

   // Fabric holds its request while the wait is high
   a_access_hold : assert property (@(posedge tx_lclk) disable iff (reset)
      (tx_io_wait && tx_access) |=> ($stable(tx_access) && $stable(tx_burst)));

   // Accept only while the fabric sees the wait low
   a_take_state : assert property (@(posedge tx_lclk) disable iff (reset)
      take |-> !tx_io_wait);

endmodule

/* logic/tx_capture.sv */
`include "elink_defs_defs.svh"

module tx_capture
(
   input  logic                     tx_lclk,
   input  logic                     reset,
   input  logic                     take,
   input  elink_pkg::emesh_packet_t tx_packet,
   output elink_pkg::link_word_u    hdr_word,
   output elink_pkg::link_word_u    pay_word
);

   // Raw packet bits, held for the whole group
   logic [`ELINK_PW-1:0]     pkt_q;
   elink_pkg::emesh_packet_t pkt;

   // ##############################
   // Packet register
   // ##############################

   // Loaded only on the accepting edge
   always_ff @(posedge tx_lclk)
   begin
      if (take)
         pkt_q <= tx_packet;
   end

   // Field view of the held packet
   assign pkt = pkt_q;

   // ##############################
   // Word packing
   // ##############################

   always_comb
   begin
      // Header word, read flag is the inverse of write
      hdr_word.hdr.unused   = '0;
      hdr_word.hdr.read     = ~pkt.write;
      hdr_word.hdr.pad      = '0;
      hdr_word.hdr.ctrlmode = pkt.ctrlmode;
      hdr_word.hdr.dstaddr  = pkt.dstaddr;
      hdr_word.hdr.datamode = pkt.datamode;
      hdr_word.hdr.write    = pkt.write;
      hdr_word.hdr.access   = pkt.access;
      // Payload word, data then srcaddr
      pay_word.pay.data     = pkt.data;
      pay_word.pay.srcaddr  = pkt.srcaddr;
   end

   // Fabric strobe and the packet access bit agree
   a_take_access : assert property (@(posedge tx_lclk) disable iff (reset)
      take |-> tx_packet.access);

endmodule

/* logic/elink_pkg.sv */
package elink_pkg;

   // ##############################
   // Fabric packet
   // ##############################

   // Emesh fields, top bit first
   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
   } emesh_packet_t;

   // ##############################
   // Link word
   // ##############################

   // Header view, only the low 48 bits go out
   typedef struct packed {
      logic [15:0] unused;
      logic        read;
      logic [6:0]  pad;
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
   } link_hdr_t;

   // Payload view, data slices go first
   typedef struct packed {
      logic [31:0] data;
      logic [31:0] srcaddr;
   } link_pay_t;

   // Same register, header in cycles 1-3, payload in 4-7
   typedef union packed {
      link_hdr_t hdr;
      link_pay_t pay;
   } link_word_u;

   // Frame state, codes in the defs header
   typedef logic [2:0] link_state_t;

endpackage

/* include/elink_defs_defs.svh */
`ifndef ELINK_DEFS_DEFS_SVH
`define ELINK_DEFS_DEFS_SVH

// ##############################
// Link geometry
// ##############################

// Fabric packet width in bits
`define ELINK_PW       104

// One link slice, sent as two DDR bytes
`define ELINK_SLICE_W  16

// ##############################
// Sequencer state codes
// ##############################

// Idle, then three header cycles and four payload cycles
`define ELINK_ST_IDLE  3'd0
`define ELINK_ST_CYC1  3'd1
`define ELINK_ST_CYC2  3'd2
`define ELINK_ST_CYC3  3'd3
`define ELINK_ST_CYC4  3'd4
`define ELINK_ST_CYC5  3'd5
`define ELINK_ST_CYC6  3'd6
`define ELINK_ST_CYC7  3'd7

`endif
